//--- src.f
logic/arm_mem_pkg.sv
logic/ldst_addr_gen.sv
logic/lane_align.sv
logic/mem_stage.sv
logic/data_ram.sv
logic/reg_file.sv
logic/mem_subsystem.sv
tb/mem_subsystem_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f src.f --top-module mem_subsystem_tb -o mem_sim
then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/mem_sim)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1

//--- tb/mem_subsystem_tb.sv
`timescale 1ns/1ps

module mem_subsystem_tb;
	import arm_mem_pkg::*;

	localparam int wait_cycles = 2;
	localparam int ram_words = 256;
	localparam int mem_bytes = ram_words * 4;
	localparam word_t window = 32'h0000_0200;
	localparam int n_fill = 64;
	localparam int n_directed = 60;
	localparam int n_random = 200;
	// Filling a word takes three steps; every step fits in wait_cycles + 4 clocks.
	localparam int n_ops = 16 + 3 * n_fill + n_directed + n_random;
	localparam int watchdog_ns = n_ops * (wait_cycles + 4) * 4 + 16 * 4;

	logic clk = 1'b0;
	logic reset;
	logic inbubble;
	word_t pc;
	insn_u insn;
	word_t base;
	word_t offset;
	logic pre_en;
	reg_num_t pre_num;
	word_t pre_data;
	logic outstall;
	logic outbubble;
	word_t outpc;
	word_t outinsn;
	wb_t wb;

	word_t shadow_regs [16];
	logic [7:0] shadow_mem [mem_bytes];
	wb_t exp_q [$];
	int exp_cyc [$];
	int cyc = 0;
	int n_pass = 0;
	int n_fail = 0;
	int fail_mark = 0;
	int stall_left = 0;
	word_t pc_val = '0;
	word_t prev_pc;
	word_t prev_insn;
	logic prev_bub;
	logic have_pc;

	mem_subsystem #(
		.wait_cycles(wait_cycles),
		.ram_words(ram_words)
	) dut0 (.*);

	always #2 clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	// Expected writebacks of one transfer, in order. The shadow state moves along with it.
	function automatic int ldst_expect(input insn_u ins, input word_t b, input word_t off,
			output wb_t first, output wb_t second);
		word_t idx_addr;
		word_t addr;
		word_t data;
		int a;
		int wa;
		int k;
		int n;
		idx_addr = ins.ldst.u ? b + off : b - off;
		addr = ins.ldst.p ? idx_addr : b;
		a = int'(addr % mem_bytes);
		wa = a - a % 4;
		first = '0;
		second = '0;
		n = 0;
		if (ins.ldst.l) begin
			for (k = 0; k < 4; k++)
				data[8*k +: 8] = shadow_mem[wa + (a + k) % 4];
			if (ins.ldst.b)
				data = {24'h000000, shadow_mem[a]};
			first.en = 1'b1;
			first.num = ins.ldst.rd;
			first.data = data;
			shadow_regs[ins.ldst.rd] = data;
			n = 1;
		end else begin
			data = shadow_regs[ins.ldst.rd];
			if (ins.ldst.b)
				shadow_mem[a] = data[7:0];
			else
				for (k = 0; k < 4; k++)
					shadow_mem[wa + k] = data[8*k +: 8];
		end
		if (ins.ldst.w || !ins.ldst.p) begin
			second.en = 1'b1;
			second.num = ins.ldst.rn;
			second.data = idx_addr;
			shadow_regs[ins.ldst.rn] = idx_addr;
			if (n == 0)
				first = second;
			n++;
		end
		return n;
	endfunction

	function automatic insn_u make_ldst(input logic p, u, bb, w, l, input reg_num_t rn, rd);
		insn_u x;
		x = '0;
		x.ldst.cond = 4'he;
		x.ldst.cls = 2'b01;
		x.ldst.p = p;
		x.ldst.u = u;
		x.ldst.b = bb;
		x.ldst.w = w;
		x.ldst.l = l;
		x.ldst.rn = rn;
		x.ldst.rd = rd;
		return x;
	endfunction

	function automatic word_t fill_word(input word_t addr);
		return (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[31:16]};
	endfunction

	task automatic check_wb(input wb_t got, input wb_t exp, input string what);
		if (got !== exp) begin
			$display("Fail at time %0t: %s r%0d = %h, expected r%0d = %h",
				$time, what, got.num, got.data, exp.num, exp.data);
			n_fail++;
		end else begin
			n_pass++;
		end
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("Fail at time %0t: %s is %h, expected %h", $time, what, got, exp);
			n_fail++;
		end else begin
			n_pass++;
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Fail at time %0t: %s is %b, expected %b", $time, what, got, exp);
			n_fail++;
		end else begin
			n_pass++;
		end
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp) begin
			$display("Fail at time %0t: writeback in cycle %0d, expected in cycle %0d",
				$time, got, exp);
			n_fail++;
		end else begin
			n_pass++;
		end
	endtask

	// Holds the inputs until the stage takes them at the edge after outstall is seen low.
	task automatic present(input logic bub, input insn_u ins, input word_t b, input word_t off,
			input logic is_xfer);
		wb_t first;
		wb_t second;
		int n;
		int c;
		int s;
		@(posedge clk);
		c = cyc;
		inbubble <= bub;
		pc <= pc_val;
		insn <= ins;
		base <= b;
		offset <= off;
		pc_val = pc_val + 4;
		s = 0;
		if (is_xfer && !bub) begin
			// Every access waits; a load with base update holds one cycle more.
			s = wait_cycles;
			if (ins.ldst.l && (ins.ldst.w || !ins.ldst.p))
				s = s + 1;
			n = ldst_expect(ins, b, off, first, second);
			if (n > 0) begin
				exp_q.push_back(first);
				exp_cyc.push_back(c + wait_cycles + 2);
			end
			if (n > 1) begin
				exp_q.push_back(second);
				exp_cyc.push_back(c + wait_cycles + 3);
			end
		end
		stall_left = s;
		@(negedge clk);
		while (outstall)
			@(negedge clk);
	endtask

	task automatic xfer(input logic p, u, bb, w, l, input reg_num_t rn, rd,
			input word_t addr, input word_t off);
		word_t b;
		b = addr;
		if (p)
			b = u ? addr - off : addr + off;
		present(1'b0, make_ldst(p, u, bb, w, l, rn, rd), b, off, 1'b1);
	endtask

	task automatic drain();
		present(1'b1, '0, '0, '0, 1'b0);
		while (exp_q.size() != 0)
			@(negedge clk);
	endtask

	task automatic preload(input reg_num_t num, input word_t data);
		@(posedge clk);
		pre_en <= 1'b1;
		pre_num <= num;
		pre_data <= data;
		@(posedge clk);
		pre_en <= 1'b0;
		shadow_regs[num] = data;
	endtask

	task automatic fill_window();
		int k;
		word_t addr;
		for (k = 0; k < n_fill; k++) begin
			addr = window + word_t'(4 * k);
			preload(4'd1, fill_word(addr));
			xfer(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 4'd0, 4'd1, addr, '0);
			drain();
		end
	endtask

	task automatic run_random();
		int t;
		logic p, u, bb, w, l;
		reg_num_t rn, rd;
		for (t = 0; t < n_random; t++) begin
			p = 1'($urandom_range(1));
			u = 1'($urandom_range(1));
			bb = 1'($urandom_range(1));
			w = 1'($urandom_range(1));
			l = 1'($urandom_range(1));
			rn = 4'($urandom_range(15));
			rd = 4'($urandom_range(15));
			xfer(p, u, bb, w, l, rn, rd, window + word_t'($urandom_range(255)),
				word_t'($urandom_range(63)));
		end
	endtask

	task automatic end_test(input string name);
		drain();
		$display("Test %s finished with %0d errors", name, n_fail - fail_mark);
		fail_mark = n_fail;
	endtask

	always @(negedge clk) begin : compare
		wb_t exp_wb;
		int exp_c;
		if (reset) begin
			have_pc = 1'b0;
		end else begin
			if (have_pc) begin
				check_word(outpc, prev_pc, "outpc");
				check_word(outinsn, prev_insn, "outinsn");
				check_bit(outbubble, prev_bub, "outbubble");
			end
			check_bit(outstall, stall_left > 0, "outstall");
			prev_pc = pc;
			prev_insn = insn;
			prev_bub = inbubble || stall_left > 0;
			if (stall_left > 0)
				stall_left--;
			have_pc = 1'b1;
			if (wb.en) begin
				if (exp_q.size() == 0) begin
					$display("Unexpected writeback to r%0d at time %0t", wb.num, $time);
					n_fail++;
				end else begin
					exp_wb = exp_q.pop_front();
					exp_c = exp_cyc.pop_front();
					check_wb(wb, exp_wb, "writeback");
					check_latency(cyc, exp_c);
				end
			end
		end
	end

	initial begin
		#(watchdog_ns);
		$display("Timeout after %0d ns, the stage stopped making progress", watchdog_ns);
		$display("Something failed");
		$finish;
	end

	initial begin
		int k;
		insn_u x;
		void'($urandom(32'hdfd3));
		reset = 1'b1;
		inbubble = 1'b1;
		pc = '0;
		insn = '0;
		base = '0;
		offset = '0;
		pre_en = 1'b0;
		pre_num = '0;
		pre_data = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		for (k = 0; k < 16; k++)
			preload(reg_num_t'(k), $urandom());
		fill_window();

		preload(4'd2, 32'hcafe_1234);
		xfer(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 4'd0, 4'd2, window + 32'h10, '0);
		xfer(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 4'd0, 4'd3, window + 32'h10, '0);
		end_test("1 word store then load");

		// Upper bytes are junk so a wrong lane strobe shows up in the load.
		for (k = 0; k < 4; k++)
			preload(reg_num_t'(4 + k), {24'hdeadbe, 8'(17 * (k + 1))});
		for (k = 0; k < 4; k++)
			xfer(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 4'd0, reg_num_t'(4 + k),
				window + 32'h20 + word_t'(k), '0);
		xfer(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 4'd0, 4'd8, window + 32'h20, '0);
		end_test("2 byte lanes");

		for (k = 1; k < 4; k++)
			xfer(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 4'd0, 4'd9, window + 32'h40 + word_t'(k), '0);
		for (k = 0; k < 4; k++)
			xfer(1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 4'd0, 4'd9, window + 32'h44 + word_t'(k), '0);
		end_test("3 unaligned loads");

		xfer(1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 4'd10, 4'd11, window + 32'h80, 32'd12);
		xfer(1'b1, 1'b0, 1'b0, 1'b1, 1'b1, 4'd10, 4'd11, window + 32'h80, 32'd12);
		xfer(1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 4'd10, 4'd11, window + 32'h80, 32'd12);
		xfer(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 4'd10, 4'd11, window + 32'h84, 32'd12);
		xfer(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 4'd10, 4'd11, window + 32'h90, 32'd8);
		xfer(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 4'd10, 4'd11, window + 32'h94, 32'd8);
		xfer(1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 4'd11, 4'd11, window + 32'h91, 32'd4);
		xfer(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 4'd0, 4'd12, window + 32'h94, '0);
		end_test("4 indexing and writeback");

		preload(4'd2, 32'h5a5a_0f0f);
		x = make_ldst(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 4'd0, 4'd2);
		present(1'b1, x, window + 32'h30, '0, 1'b0);
		x.cls.cls = 3'b100;
		present(1'b0, x, window + 32'h30, '0, 1'b0);
		x.cls.cls = 3'b011;
		x.ldst.imm[4] = 1'b1;
		present(1'b0, x, window + 32'h30, '0, 1'b0);
		x.cls.cls = 3'b000;
		present(1'b0, x, window + 32'h30, '0, 1'b0);
		xfer(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 4'd0, 4'd12, window + 32'h30, '0);
		end_test("5 bubbles and non-transfers");

		run_random();
		end_test("6 random transfers");

		$display("Checks passed: %0d, failed: %0d", n_pass, n_fail);
		if (n_fail == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- logic/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem #(
	parameter int wait_cycles = 2,
	parameter int ram_words = 256
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  inbubble,
	input  arm_mem_pkg::word_t    pc,
	input  arm_mem_pkg::insn_u    insn,
	input  arm_mem_pkg::word_t    base,
	input  arm_mem_pkg::word_t    offset,
	input  logic                  pre_en,
	input  arm_mem_pkg::reg_num_t pre_num,
	input  arm_mem_pkg::word_t    pre_data,
	output logic                  outstall,
	output logic                  outbubble,
	output arm_mem_pkg::word_t    outpc,
	output arm_mem_pkg::word_t    outinsn,
	output arm_mem_pkg::wb_t      wb
);
	import arm_mem_pkg::*;

	bus_req_t bus;
	logic rw_wait;
	word_t rd_data;
	reg_num_t st_read;
	word_t st_data;

	mem_stage stage0 (
		.clk(clk),
		.reset(reset),
		.inbubble(inbubble),
		.pc(pc),
		.insn(insn),
		.base(base),
		.offset(offset),
		.bus(bus),
		.rw_wait(rw_wait),
		.rd_data(rd_data),
		.st_read(st_read),
		.st_data(st_data),
		.outstall(outstall),
		.outbubble(outbubble),
		.outpc(outpc),
		.outinsn(outinsn),
		.wb(wb)
	);

	data_ram #(
		.wait_cycles(wait_cycles),
		.ram_words(ram_words)
	) ram0 (
		.clk(clk),
		.reset(reset),
		.bus(bus),
		.rw_wait(rw_wait),
		.rd_data(rd_data)
	);

	reg_file regs0 (
		.clk(clk),
		.reset(reset),
		.rd_num(st_read),
		.rd_data(st_data),
		.wb(wb),
		.pre_en(pre_en),
		.pre_num(pre_num),
		.pre_data(pre_data)
	);

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                  clk,
	input  logic                  reset,
	input  arm_mem_pkg::reg_num_t rd_num,
	output arm_mem_pkg::word_t    rd_data,
	input  arm_mem_pkg::wb_t      wb,
	input  logic                  pre_en,
	input  arm_mem_pkg::reg_num_t pre_num,
	input  arm_mem_pkg::word_t    pre_data
);
	import arm_mem_pkg::*;

	word_t regs [16];

	assign rd_data = regs[rd_num];

	// The preload is assigned last so it takes priority on a clash.
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else begin
			if (wb.en)
				regs[wb.num] <= wb.data;
			if (pre_en)
				regs[pre_num] <= pre_data;
		end
	end

endmodule

//--- logic/data_ram.sv
`timescale 1ns/1ps

module data_ram #(
	parameter int wait_cycles = 2,
	parameter int ram_words = 256
) (
	input  logic                  clk,
	input  logic                  reset,
	input  arm_mem_pkg::bus_req_t bus,
	output logic                  rw_wait,
	output arm_mem_pkg::word_t    rd_data
);
	import arm_mem_pkg::*;

	localparam int cnt_w = (wait_cycles > 0) ? $clog2(wait_cycles + 1) : 1;
	localparam int idx_w = (ram_words > 1) ? $clog2(ram_words) : 1;

	word_t mem [ram_words];
	logic [cnt_w-1:0] cnt;
	logic [31:0] word_idx;
	logic [idx_w-1:0] idx;
	logic req;

	// Addresses past the array wrap around.
	always_comb begin
		word_idx = {2'b00, bus.addr[31:2]} % ram_words;
		idx = word_idx[idx_w-1:0];
	end

	assign req = bus.rd || bus.wr;
	assign rw_wait = req && (cnt < wait_cycles);
	assign rd_data = mem[idx];

	// Counts waited cycles of the current access and restarts once it completes.
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
		end else if (rw_wait) begin
			cnt <= cnt + 1'b1;
		end else begin
			cnt <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (bus.wr && !rw_wait) begin
			for (int i = 0; i < 4; i++) begin
				if (bus.strb[i])
					mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
			end
		end
	end

endmodule

//--- logic/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  inbubble,
	input  arm_mem_pkg::word_t    pc,
	input  arm_mem_pkg::insn_u    insn,
	input  arm_mem_pkg::word_t    base,
	input  arm_mem_pkg::word_t    offset,
	output arm_mem_pkg::bus_req_t bus,
	input  logic                  rw_wait,
	input  arm_mem_pkg::word_t    rd_data,
	output arm_mem_pkg::reg_num_t st_read,
	input  arm_mem_pkg::word_t    st_data,
	output logic                  outstall,
	output logic                  outbubble,
	output arm_mem_pkg::word_t    outpc,
	output arm_mem_pkg::word_t    outinsn,
	output arm_mem_pkg::wb_t      wb
);
	import arm_mem_pkg::*;

	insn_kind_e kind;
	word_t indexed;
	word_t xfer_addr;
	word_t st_word;
	word_t ld_data;
	word_t wr_data;
	logic [3:0] strobes;
	logic active;
	logic is_load;
	logic base_wb;
	logic done;
	logic pend;
	logic pend_next;
	wb_t wb_next;

	ldst_addr_gen addr_gen0 (
		.base(base),
		.offset(offset),
		.insn(insn),
		.indexed(indexed),
		.xfer_addr(xfer_addr)
	);

	lane_align align0 (
		.byte_off(xfer_addr[1:0]),
		.is_byte(insn.ldst.b),
		.rd_word(rd_data),
		.st_word(st_word),
		.ld_data(ld_data),
		.wr_data(wr_data),
		.strobes(strobes)
	);

	// The register file has not yet taken the previous writeback, so forward it.
	assign st_read = insn.ldst.rd;
	assign st_word = (wb.en && wb.num == st_read) ? wb.data : st_data;

	always_comb begin
		kind = decode_kind(insn);
		active = !inbubble && kind == ldst;
		is_load = insn.ldst.l;
		base_wb = insn.ldst.w || !insn.ldst.p;
		done = active && !pend && !rw_wait;

		bus.addr = {xfer_addr[31:2], 2'b00};
		bus.rd = active && !pend && is_load;
		bus.wr = active && !pend && !is_load;
		bus.strb = strobes;
		bus.wdata = wr_data;

		// A load with base update keeps upstream one more cycle for the second writeback.
		outstall = active && !pend && (rw_wait || (is_load && base_wb));
	end

	always_comb begin
		wb_next.en = 1'b0;
		wb_next.num = insn.ldst.rd;
		wb_next.data = ld_data;
		if (pend) begin
			wb_next.en = 1'b1;
			wb_next.num = insn.ldst.rn;
			wb_next.data = indexed;
		end else if (done) begin
			if (is_load) begin
				wb_next.en = 1'b1;
			end else if (base_wb) begin
				wb_next.en = 1'b1;
				wb_next.num = insn.ldst.rn;
				wb_next.data = indexed;
			end
		end
		pend_next = done && is_load && base_wb;
	end

	always_ff @(posedge clk) begin
		outpc <= pc;
		outinsn <= insn;
		wb.num <= wb_next.num;
		wb.data <= wb_next.data;
		if (reset) begin
			wb.en <= 1'b0;
			outbubble <= 1'b1;
			pend <= 1'b0;
		end else begin
			wb.en <= wb_next.en;
			outbubble <= inbubble || outstall;
			pend <= pend_next;
		end
	end

endmodule

//--- logic/lane_align.sv
`timescale 1ns/1ps

module lane_align (
	input  logic [1:0]         byte_off,
	input  logic               is_byte,
	input  arm_mem_pkg::word_t rd_word,
	input  arm_mem_pkg::word_t st_word,
	output arm_mem_pkg::word_t ld_data,
	output arm_mem_pkg::word_t wr_data,
	output logic [3:0]         strobes
);
	import arm_mem_pkg::*;

	word_t rot_half;
	word_t rot_byte;

	// Load path: rotate right by halfword, then by byte.
	always_comb begin
		if (byte_off[1])
			rot_half = {rd_word[15:0], rd_word[31:16]};
		else
			rot_half = rd_word;

		if (byte_off[0])
			rot_byte = {rot_half[7:0], rot_half[31:8]};
		else
			rot_byte = rot_half;
	end

	always_comb begin
		if (is_byte)
			ld_data = {24'h000000, rot_byte[7:0]};
		else
			ld_data = rot_byte;
	end

	// Store path. A byte goes to every lane and the strobe picks the one that lands.
	always_comb begin
		if (is_byte) begin
			wr_data = {4{st_word[7:0]}};
			case (byte_off)
				2'd0: strobes = 4'b0001;
				2'd1: strobes = 4'b0010;
				2'd2: strobes = 4'b0100;
				default: strobes = 4'b1000;
			endcase
		end else begin
			wr_data = st_word;
			strobes = 4'b1111;
		end
	end

endmodule

//--- logic/ldst_addr_gen.sv
`timescale 1ns/1ps

module ldst_addr_gen (
	input  arm_mem_pkg::word_t base,
	input  arm_mem_pkg::word_t offset,
	input  arm_mem_pkg::insn_u insn,
	output arm_mem_pkg::word_t indexed,
	output arm_mem_pkg::word_t xfer_addr
);
	import arm_mem_pkg::*;

	word_t sum;
	word_t diff;

	always_comb begin
		sum = base + offset;
		diff = base - offset;
	end

	// U picks the offset direction.
	always_comb begin
		if (insn.ldst.u)
			indexed = sum;
		else
			indexed = diff;
	end

	// Pre-index transfers at the indexed address, post-index at the base.
	always_comb begin
		if (insn.ldst.p)
			xfer_addr = indexed;
		else
			xfer_addr = base;
	end

endmodule

//--- logic/arm_mem_pkg.sv
package arm_mem_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_num_t;

	// Single data transfer layout.
	typedef struct packed {
		logic [3:0]  cond;
		logic [1:0]  cls;
		logic        i;
		logic        p;
		logic        u;
		logic        b;
		logic        w;
		logic        l;
		reg_num_t    rn;
		reg_num_t    rd;
		logic [11:0] imm;
	} ldst_view_t;

	// Coarse layout used only to classify the word.
	typedef struct packed {
		logic [3:0]  cond;
		logic [2:0]  cls;
		logic [24:0] rest;
	} cls_view_t;

	typedef union packed {
		ldst_view_t ldst;
		cls_view_t  cls;
	} insn_u;

	typedef enum logic [1:0] {
		ldst,
		block,
		other
	} insn_kind_e;

	typedef struct packed {
		word_t      addr;
		logic       rd;
		logic       wr;
		logic [3:0] strb;
		word_t      wdata;
	} bus_req_t;

	typedef struct packed {
		logic     en;
		reg_num_t num;
		word_t    data;
	} wb_t;

	// A register offset with bit 4 set is the undefined space, not a transfer.
	function automatic insn_kind_e decode_kind(insn_u insn);
		insn_kind_e kind;
		kind = other;
		if (insn.cls.cls[2:1] == 2'b01) begin
			if (!(insn.ldst.i && insn.ldst.imm[4]))
				kind = ldst;
		end else if (insn.cls.cls == 3'b100) begin
			kind = block;
		end
		return kind;
	endfunction

endpackage
